//--- chdr_ingress_port.f
chdr_route_pkg.sv
stream_fifo.sv
packet_gate.sv
epid_route_table.sv
chdr_ingress_buff.sv
chdr_ingress_port.sv
chdr_ingress_port_checker.sv
chdr_ingress_port_tb.sv

//--- chdr_ingress_port_tb.sv
/*
  CHDR ingress port testbench
  Drives packets of all routing classes, keeps a mirror of the routing
  table and compares every output word with a reference model
*/

`timescale 1ns/1ps
`default_nettype none

module chdr_ingress_port_tb;

  localparam int DEST_W    = 4;
  localparam int MTU       = 5;
  localparam int NODE_ID   = 5;
  localparam int N_ENTRIES = 8;
  localparam int IDX_W     = $clog2(N_ENTRIES);
  localparam int CW        = chdr_route_pkg::chdr_w;

  logic                    clk = 1'b0;
  logic                    reset;
  logic [CW-1:0]           i_data;
  logic [DEST_W-1:0]       i_dest;
  chdr_route_pkg::pkt_id_t i_id;
  logic                    i_last;
  logic                    i_valid;
  logic                    o_ready;
  logic [CW-1:0]           o_data;
  logic [DEST_W-1:0]       o_dest;
  logic                    o_keep;
  logic                    o_last;
  logic                    o_valid;
  logic                    i_ready;
  logic                    i_cfg_wr;
  logic [IDX_W-1:0]        i_cfg_index;
  chdr_route_pkg::epid_t   i_cfg_epid;
  logic [DEST_W-1:0]       i_cfg_port;

  // Mirror of the routing table as written
  logic                  mir_valid [N_ENTRIES];
  chdr_route_pkg::epid_t mir_epid  [N_ENTRIES];
  logic [DEST_W-1:0]     mir_port  [N_ENTRIES];

  // Expected output words in order
  logic [CW-1:0]     exp_data [$];
  logic              exp_last [$];
  logic [DEST_W-1:0] exp_port [$];
  logic              exp_keep [$];

  logic [31:0] stim_seed = 32'd80768;
  logic [31:0] rdy_seed  = 32'd80768 ^ 32'h0000_ffff;
  logic        rdy_random = 1'b0;
  logic        in_fire;
  int          errors = 0;
  int          failed_tests = 0;
  int          total_words = 0;
  int          cycle_cnt = 0;

  chdr_ingress_port #(
    .DEST_W    (DEST_W),
    .MTU       (MTU),
    .NODE_ID   (NODE_ID),
    .N_ENTRIES (N_ENTRIES)
  ) chdr_ingress_port_i (
    .clk         (clk),
    .reset       (reset),
    .i_data      (i_data),
    .i_dest      (i_dest),
    .i_id        (i_id),
    .i_last      (i_last),
    .i_valid     (i_valid),
    .o_ready     (o_ready),
    .o_data      (o_data),
    .o_dest      (o_dest),
    .o_keep      (o_keep),
    .o_last      (o_last),
    .o_valid     (o_valid),
    .i_ready     (i_ready),
    .i_cfg_wr    (i_cfg_wr),
    .i_cfg_index (i_cfg_index),
    .i_cfg_epid  (i_cfg_epid),
    .i_cfg_port  (i_cfg_port)
  );

  always #50 clk = ~clk;

  // ----------------------------------------
  // Random numbers and reference model
  // ----------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic int unsigned rnd(input int unsigned n);
    stim_seed = lcg_next(stim_seed);
    return stim_seed[30:16] % n;
  endfunction

  function automatic logic [31:0] rnd32();
    logic [31:0] r;
    stim_seed = lcg_next(stim_seed);
    r[31:16] = stim_seed[31:16];
    stim_seed = lcg_next(stim_seed);
    r[15:0] = stim_seed[31:16];
    return r;
  endfunction

  // Returns {keep, port}; first matching entry from index 0 up wins
  function automatic logic [DEST_W:0] ref_route(input chdr_route_pkg::pkt_id_t id,
                                                 input chdr_route_pkg::epid_t epid,
                                                 input logic [DEST_W-1:0] dest);
    logic [DEST_W:0] r;
    logic            found;
    found = 1'b0;
    r = {1'b1, dest};
    if (id == chdr_route_pkg::ID_RETURN_SRC) begin
      r = {1'b1, DEST_W'(NODE_ID)};
    end else if (id == chdr_route_pkg::ID_ROUTE_EPID) begin
      r = '0;
      for (int i = 0; i < N_ENTRIES; i++) begin
        if (!found && mir_valid[i] && mir_epid[i] == epid) begin
          found = 1'b1;
          r = {1'b1, mir_port[i]};
        end
      end
    end
    return r;
  endfunction

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic check_word(input logic [CW-1:0] got_data, input logic [CW-1:0] want_data,
                            input logic got_last, input logic want_last);
    if (got_data !== want_data) begin
      $display("Fail o_data: got %h, expected %h", got_data, want_data);
      errors++;
    end
    if (got_last !== want_last) begin
      $display("Fail o_last: got %h, expected %h", got_last, want_last);
      errors++;
    end
  endtask

  task automatic check_dest(input logic [DEST_W-1:0] got_port, input logic [DEST_W-1:0] want_port,
                            input logic got_keep, input logic want_keep);
    if (got_port !== want_port) begin
      $display("Fail o_dest: got %h, expected %h", got_port, want_port);
      errors++;
    end
    if (got_keep !== want_keep) begin
      $display("Fail o_keep: got %h, expected %h", got_keep, want_keep);
      errors++;
    end
  endtask

  // ----------------------------------------
  // Monitor, ready source and timeout
  // ----------------------------------------

  always @(posedge clk) begin
    in_fire <= !reset && i_valid && o_ready;
    if (!reset && o_valid && i_ready) begin
      if (exp_data.size() == 0) begin
        $display("Output word %h appeared with no packet pending", o_data);
        errors++;
      end else begin
        check_word(o_data, exp_data.pop_front(), o_last, exp_last.pop_front());
        check_dest(o_dest, exp_port.pop_front(), o_keep, exp_keep.pop_front());
      end
    end
  end

  // Ready is high three times in four when random
  always @(negedge clk) begin
    rdy_seed = lcg_next(rdy_seed);
    i_ready = rdy_random ? (rdy_seed[29:28] != 2'b00) : 1'b1;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > 10 * total_words + 200) begin
      $display("Timeout after %0d cycles, packets stopped leaving the DUT", cycle_cnt);
      $display("Checks failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Stimulus tasks
  // ----------------------------------------

  task automatic cfg_write(input logic [IDX_W-1:0] idx, input chdr_route_pkg::epid_t epid,
                           input logic [DEST_W-1:0] port);
    i_cfg_wr    = 1'b1;
    i_cfg_index = idx;
    i_cfg_epid  = epid;
    i_cfg_port  = port;
    mir_valid[idx] = 1'b1;
    mir_epid[idx]  = epid;
    mir_port[idx]  = port;
    @(negedge clk);
    i_cfg_wr = 1'b0;
  endtask

  task automatic expect_output_idle();
    if (o_valid) begin
      $display("o_valid rose before the last word of the packet was accepted");
      errors++;
    end
  endtask

  // Sends one packet; hold_last withholds the last word and checks gating
  task automatic send_packet(input chdr_route_pkg::pkt_id_t id, input logic [DEST_W-1:0] dest,
                             input chdr_route_pkg::epid_t epid, input int len,
                             input int max_gap, input int hold_last);
    logic [DEST_W:0] route;
    logic [CW-1:0]   word;
    int              gap;
    route = ref_route(id, epid, dest);
    for (int w = 0; w < len; w++) begin
      word = {rnd32(), rnd32()};
      if (w == 0) begin
        word[chdr_route_pkg::epid_lsb +: chdr_route_pkg::epid_w] = epid;
      end
      gap = 0;
      if (max_gap > 0 && rnd(4) == 0) begin
        gap = rnd(max_gap) + 1;
      end
      if (w == len - 1) begin
        gap = gap + hold_last;
      end
      i_valid = 1'b0;
      repeat (gap) begin
        @(negedge clk);
        if (hold_last > 0 && w == len - 1) begin
          expect_output_idle();
        end
      end
      exp_data.push_back(word);
      exp_last.push_back(w == len - 1);
      exp_port.push_back(route[DEST_W-1:0]);
      exp_keep.push_back(route[DEST_W]);
      total_words++;
      i_data  = word;
      i_last  = (w == len - 1);
      i_id    = id;
      i_dest  = dest;
      i_valid = 1'b1;
      do begin
        @(negedge clk);
        if (hold_last > 0 && w == len - 1 && !in_fire) begin
          expect_output_idle();
        end
      end while (!in_fire);
    end
    i_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_data.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic finish_test(input int num, input string name, input int err_before);
    if (errors == err_before) begin
      $display("Test %0d %s: ok", num, name);
    end else begin
      $display("Test %0d %s: %0d errors", num, name, errors - err_before);
      failed_tests++;
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    int err0;
    reset       = 1'b1;
    i_data      = '0;
    i_dest      = '0;
    i_id        = chdr_route_pkg::ID_DATA;
    i_last      = 1'b0;
    i_valid     = 1'b0;
    i_ready     = 1'b0;
    i_cfg_wr    = 1'b0;
    i_cfg_index = '0;
    i_cfg_epid  = '0;
    i_cfg_port  = '0;
    for (int i = 0; i < N_ENTRIES; i++) begin
      mir_valid[i] = 1'b0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Table hits, two entries share an endpoint ID
    err0 = errors;
    cfg_write(3'd0, 16'h00aa, 4'h7);
    cfg_write(3'd2, 16'h1234, 4'h9);
    cfg_write(3'd5, 16'h1234, 4'h3);
    send_packet(chdr_route_pkg::ID_ROUTE_EPID, 4'h1, 16'h1234, 3, 0, 0);
    send_packet(chdr_route_pkg::ID_ROUTE_EPID, 4'h1, 16'h00aa, 2, 0, 0);
    wait_drain();
    finish_test(1, "route by endpoint ID", err0);

    err0 = errors;
    send_packet(chdr_route_pkg::ID_ROUTE_EPID, 4'h2, 16'hbeef, 4, 0, 0);
    wait_drain();
    finish_test(2, "table miss", err0);

    err0 = errors;
    send_packet(chdr_route_pkg::ID_RETURN_SRC, 4'ha, 16'h1234, 3, 0, 0);
    send_packet(chdr_route_pkg::ID_DATA, 4'hc, 16'h1234, 2, 0, 0);
    send_packet(chdr_route_pkg::pkt_id_t'(3), 4'h2, 16'h00aa, 1, 0, 0);
    wait_drain();
    finish_test(3, "return to source and data class", err0);

    err0 = errors;
    send_packet(chdr_route_pkg::ID_DATA, 4'h6, 16'h0042, 4, 0, 20);
    wait_drain();
    finish_test(4, "store and forward gating", err0);

    // Bursts under random back-pressure with table rewrites in between
    err0 = errors;
    rdy_random = 1'b1;
    for (int b = 0; b < 4; b++) begin
      wait_drain();
      repeat (3) begin
        cfg_write(IDX_W'(rnd(N_ENTRIES)), chdr_route_pkg::epid_t'(16'h0100 + rnd(8)),
                  DEST_W'(rnd(16)));
      end
      for (int p = 0; p < 10; p++) begin
        send_packet(chdr_route_pkg::pkt_id_t'(rnd(4)), DEST_W'(rnd(16)),
                    chdr_route_pkg::epid_t'(16'h0100 + rnd(10)), int'(rnd(8)) + 1, 3, 0);
      end
    end
    wait_drain();
    rdy_random = 1'b0;
    finish_test(5, "random traffic", err0);

    if (chdr_ingress_port_i.chdr_ingress_port_checker_i.assert_fails != 0) begin
      $display("Checker assertions failed %0d times",
               chdr_ingress_port_i.chdr_ingress_port_checker_i.assert_fails);
      errors = errors + chdr_ingress_port_i.chdr_ingress_port_checker_i.assert_fails;
    end
    $display("Tests run 5, failing %0d, errors %0d, words sent %0d",
             failed_tests, errors, total_words);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- chdr_ingress_port_checker.sv
/*
  CHDR ingress port checker
  Bound assertions on the output stream for hold under back-pressure,
  constant port and keep within a packet and idle output after reset
*/

`timescale 1ns/1ps
`default_nettype none

module chdr_ingress_port_checker #(
  parameter int DEST_W = 4
) (
  input logic                              clk,
  input logic                              reset,
  input logic [chdr_route_pkg::chdr_w-1:0] o_data,
  input logic [DEST_W-1:0]                 o_dest,
  input logic                              o_keep,
  input logic                              o_last,
  input logic                              o_valid,
  input logic                              i_ready
);

  logic              in_body;
  logic [DEST_W-1:0] pkt_dest;
  logic              pkt_keep;

  // Count of failed assertions
  int assert_fails = 0;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_body <= 1'b0;
    end else if (o_valid && i_ready) begin
      in_body <= !o_last;
    end
  end

  always_ff @(posedge clk) begin
    if (o_valid && i_ready) begin
      pkt_dest <= o_dest;
      pkt_keep <= o_keep;
    end
  end

  // ----------------------------------------
  // Properties
  // ----------------------------------------

  a_hold_stalled: assert property (@(posedge clk) disable iff (reset)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_data) && $stable(o_last) &&
                               $stable(o_dest) && $stable(o_keep)))
  else begin
    $error("Output stream changed while stalled by i_ready");
    assert_fails++;
  end

  a_dest_constant: assert property (@(posedge clk) disable iff (reset)
    (in_body && o_valid) |-> ((o_dest == pkt_dest) && (o_keep == pkt_keep)))
  else begin
    $error("o_dest or o_keep changed inside a packet");
    assert_fails++;
  end

  a_idle_after_reset: assert property (@(posedge clk) reset |=> !o_valid)
  else begin
    $error("o_valid high in the cycle after reset");
    assert_fails++;
  end

endmodule

bind chdr_ingress_port chdr_ingress_port_checker #(
  .DEST_W (DEST_W)
) chdr_ingress_port_checker_i (
  .clk     (clk),
  .reset   (reset),
  .o_data  (o_data),
  .o_dest  (o_dest),
  .o_keep  (o_keep),
  .o_last  (o_last),
  .o_valid (o_valid),
  .i_ready (i_ready)
);

`default_nettype wire

//--- chdr_ingress_port.sv
/*
  CHDR ingress port
  Ingress buffer steered by its endpoint routing table
*/

`timescale 1ns/1ps
`default_nettype none

module chdr_ingress_port #(
  parameter int DEST_W    = 4,
  parameter int MTU       = 5,
  parameter int NODE_ID   = 0,
  parameter int N_ENTRIES = 8
) (
  input  logic                              clk,
  input  logic                              reset,
  // Input packet stream
  input  logic [chdr_route_pkg::chdr_w-1:0] i_data,
  input  logic [DEST_W-1:0]                 i_dest,
  input  chdr_route_pkg::pkt_id_t           i_id,
  input  logic                              i_last,
  input  logic                              i_valid,
  output logic                              o_ready,
  // Output packet stream with port and keep flag
  output logic [chdr_route_pkg::chdr_w-1:0] o_data,
  output logic [DEST_W-1:0]                 o_dest,
  output logic                              o_keep,
  output logic                              o_last,
  output logic                              o_valid,
  input  logic                              i_ready,
  // Routing table writes
  input  logic                              i_cfg_wr,
  input  logic [$clog2(N_ENTRIES)-1:0]      i_cfg_index,
  input  chdr_route_pkg::epid_t             i_cfg_epid,
  input  logic [DEST_W-1:0]                 i_cfg_port
);

  chdr_route_pkg::epid_t find_epid;
  logic                  find_valid;
  logic                  find_ready;
  logic [DEST_W-1:0]     result_port;
  logic                  result_hit;
  logic                  result_valid;
  logic                  result_ready;

  chdr_ingress_buff #(
    .DEST_W  (DEST_W),
    .MTU     (MTU),
    .NODE_ID (NODE_ID)
  ) chdr_ingress_buff_i (
    .clk            (clk),
    .reset          (reset),
    .i_data         (i_data),
    .i_dest         (i_dest),
    .i_id           (i_id),
    .i_last         (i_last),
    .i_valid        (i_valid),
    .o_ready        (o_ready),
    .o_data         (o_data),
    .o_dest         (o_dest),
    .o_keep         (o_keep),
    .o_last         (o_last),
    .o_valid        (o_valid),
    .i_ready        (i_ready),
    .o_find_epid    (find_epid),
    .o_find_valid   (find_valid),
    .i_find_ready   (find_ready),
    .i_result_port  (result_port),
    .i_result_hit   (result_hit),
    .i_result_valid (result_valid),
    .o_result_ready (result_ready)
  );

  epid_route_table #(
    .DEST_W    (DEST_W),
    .N_ENTRIES (N_ENTRIES)
  ) epid_route_table_i (
    .clk            (clk),
    .reset          (reset),
    .i_cfg_wr       (i_cfg_wr),
    .i_cfg_index    (i_cfg_index),
    .i_cfg_epid     (i_cfg_epid),
    .i_cfg_port     (i_cfg_port),
    .i_find_epid    (find_epid),
    .i_find_valid   (find_valid),
    .o_find_ready   (find_ready),
    .o_result_port  (result_port),
    .o_result_hit   (result_hit),
    .o_result_valid (result_valid),
    .i_result_ready (result_ready)
  );

endmodule

`default_nettype wire

//--- chdr_ingress_buff.sv
/*
  CHDR ingress buffer
  Gates each packet until it is complete and attaches an output port and
  keep flag, taken from the routing table or from the packet ID
*/

`timescale 1ns/1ps
`default_nettype none

module chdr_ingress_buff #(
  parameter int DEST_W  = 4,
  parameter int MTU     = 5,
  parameter int NODE_ID = 0
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [chdr_route_pkg::chdr_w-1:0]   i_data,
  input  logic [DEST_W-1:0]                   i_dest,
  input  chdr_route_pkg::pkt_id_t             i_id,
  input  logic                                i_last,
  input  logic                                i_valid,
  output logic                                o_ready,
  output logic [chdr_route_pkg::chdr_w-1:0]   o_data,
  output logic [DEST_W-1:0]                   o_dest,
  output logic                                o_keep,
  output logic                                o_last,
  output logic                                o_valid,
  input  logic                                i_ready,
  output chdr_route_pkg::epid_t               o_find_epid,
  output logic                                o_find_valid,
  input  logic                                i_find_ready,
  input  logic [DEST_W-1:0]                   i_result_port,
  input  logic                                i_result_hit,
  input  logic                                i_result_valid,
  output logic                                o_result_ready
);

  typedef chdr_route_pkg::epid_t find_t;

  typedef struct packed {
    logic              keep;
    logic [DEST_W-1:0] port;
  } dest_t;

  localparam logic st_head = 1'b0;
  localparam logic st_body = 1'b1;
  localparam logic [DEST_W-1:0] node_port = DEST_W'(NODE_ID);

  logic  in_state;
  logic  out_state;
  logic  in_accept;
  logic  out_accept;
  logic  is_route;
  logic  gate_in_ready;
  logic  gate_out_valid;
  logic  gate_out_ready;
  logic  find_push;
  logic  find_in_ready;
  logic  dest_push;
  logic  dest_in_valid;
  logic  dest_in_ready;
  logic  dest_out_valid;
  logic  dest_pop;
  logic  result_take;
  dest_t dest_in;
  dest_t dest_out;
  dest_t dest_hold;
  // Lookups still owed a result, at most find queue depth plus one
  logic [2:0] pend_cnt;

  // ----------------------------------------
  // Head/body trackers
  // ----------------------------------------

  assign in_accept  = i_valid && o_ready;
  assign out_accept = o_valid && i_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_state  <= st_head;
      out_state <= st_head;
    end else begin
      if (in_accept) begin
        in_state <= i_last ? st_head : st_body;
      end
      if (out_accept) begin
        out_state <= o_last ? st_head : st_body;
      end
    end
  end

  // ----------------------------------------
  // Input side
  // ----------------------------------------

  assign is_route  = (i_id == chdr_route_pkg::ID_ROUTE_EPID);
  assign find_push = (in_state == st_head) && in_accept && is_route;
  assign dest_push = (in_state == st_head) && in_accept && !is_route;

  // A direct destination must wait behind pending lookups to keep order
  assign o_ready = gate_in_ready &&
    ((in_state == st_body) ||
     (is_route ? find_in_ready : (dest_in_ready && !i_result_valid && pend_cnt == '0)));

  always_ff @(posedge clk) begin
    if (reset) begin
      pend_cnt <= '0;
    end else if (find_push && !result_take) begin
      pend_cnt <= pend_cnt + 1'b1;
    end else if (result_take && !find_push) begin
      pend_cnt <= pend_cnt - 1'b1;
    end
  end

  packet_gate #(
    .WIDTH (chdr_route_pkg::chdr_w),
    .MTU   (MTU)
  ) packet_gate_i (
    .clk     (clk),
    .reset   (reset),
    .i_data  (i_data),
    .i_last  (i_last),
    .i_valid (in_accept),
    .o_ready (gate_in_ready),
    .o_data  (o_data),
    .o_last  (o_last),
    .o_valid (gate_out_valid),
    .i_ready (gate_out_ready)
  );

  stream_fifo #(
    .T     (find_t),
    .DEPTH (2)
  ) find_fifo_i (
    .clk     (clk),
    .reset   (reset),
    .i_data  (chdr_route_pkg::get_dst_epid(i_data)),
    .i_valid (find_push),
    .o_ready (find_in_ready),
    .o_data  (o_find_epid),
    .o_valid (o_find_valid),
    .i_ready (i_find_ready)
  );

  // ----------------------------------------
  // Destination queue
  // ----------------------------------------

  // Table results win the queue input
  assign result_take    = i_result_valid && dest_in_ready;
  assign o_result_ready = dest_in_ready;
  assign dest_in_valid  = i_result_valid || dest_push;

  always_comb begin
    if (i_result_valid) begin
      dest_in.keep = i_result_hit;
      dest_in.port = i_result_port;
    end else begin
      dest_in.keep = 1'b1;
      dest_in.port = (i_id == chdr_route_pkg::ID_RETURN_SRC) ? node_port : i_dest;
    end
  end

  stream_fifo #(
    .T     (dest_t),
    .DEPTH (2)
  ) dest_fifo_i (
    .clk     (clk),
    .reset   (reset),
    .i_data  (dest_in),
    .i_valid (dest_in_valid),
    .o_ready (dest_in_ready),
    .o_data  (dest_out),
    .o_valid (dest_out_valid),
    .i_ready (dest_pop)
  );

  // ----------------------------------------
  // Output side
  // ----------------------------------------

  assign gate_out_ready = i_ready && ((out_state == st_body) || dest_out_valid);
  assign o_valid        = gate_out_valid && ((out_state == st_body) || dest_out_valid);
  assign dest_pop       = out_accept && (out_state == st_head);

  // Hold the entry for the body words of the packet
  always_ff @(posedge clk) begin
    if (dest_pop) begin
      dest_hold <= dest_out;
    end
  end

  assign o_dest = (out_state == st_head) ? dest_out.port : dest_hold.port;
  assign o_keep = (out_state == st_head) ? dest_out.keep : dest_hold.keep;

endmodule

`default_nettype wire

//--- epid_route_table.sv
/*
  Endpoint routing table
  Associative table mapping endpoint IDs to output ports, written through
  single-cycle config strobes and queried through a lookup/result stream
*/

`timescale 1ns/1ps
`default_nettype none

module epid_route_table #(
  parameter int DEST_W    = 4,
  parameter int N_ENTRIES = 8
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         i_cfg_wr,
  input  logic [$clog2(N_ENTRIES)-1:0] i_cfg_index,
  input  chdr_route_pkg::epid_t        i_cfg_epid,
  input  logic [DEST_W-1:0]            i_cfg_port,
  input  chdr_route_pkg::epid_t        i_find_epid,
  input  logic                         i_find_valid,
  output logic                         o_find_ready,
  output logic [DEST_W-1:0]            o_result_port,
  output logic                         o_result_hit,
  output logic                         o_result_valid,
  input  logic                         i_result_ready
);

  logic [N_ENTRIES-1:0]  ent_valid;
  chdr_route_pkg::epid_t ent_epid [N_ENTRIES];
  logic [DEST_W-1:0]     ent_port [N_ENTRIES];

  logic              find_take;
  logic              match_hit;
  logic [DEST_W-1:0] match_port;

  // ----------------------------------------
  // Configuration writes
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      ent_valid <= '0;
    end else if (i_cfg_wr && (i_cfg_index < N_ENTRIES)) begin
      ent_valid[i_cfg_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_cfg_wr && (i_cfg_index < N_ENTRIES)) begin
      ent_epid[i_cfg_index] <= i_cfg_epid;
      ent_port[i_cfg_index] <= i_cfg_port;
    end
  end

  // ----------------------------------------
  // Lookup
  // ----------------------------------------

  // Scan from the top down so the lowest matching index is left standing
  always_comb begin
    match_hit  = 1'b0;
    match_port = '0;
    for (int i = N_ENTRIES - 1; i >= 0; i--) begin
      if (ent_valid[i] && (ent_epid[i] == i_find_epid)) begin
        match_hit  = 1'b1;
        match_port = ent_port[i];
      end
    end
  end

  // One result in flight at a time
  assign o_find_ready = !o_result_valid;
  assign find_take    = i_find_valid && o_find_ready;

  always_ff @(posedge clk) begin
    if (find_take) begin
      o_result_port <= match_port;
      o_result_hit  <= match_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      o_result_valid <= 1'b0;
    end else if (find_take) begin
      o_result_valid <= 1'b1;
    end else if (i_result_ready) begin
      o_result_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- packet_gate.sv
/*
  Packet gate
  Store-and-forward buffer: a packet is held in memory until its last
  word has been written, then released word by word
*/

`timescale 1ns/1ps
`default_nettype none

module packet_gate #(
  parameter int WIDTH = 64,
  parameter int MTU   = 5
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_last,
  input  logic             i_valid,
  output logic             o_ready,
  output logic [WIDTH-1:0] o_data,
  output logic             o_last,
  output logic             o_valid,
  input  logic             i_ready
);

  localparam int depth = 2 ** MTU;

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  logic [WIDTH-1:0] data_mem [depth];
  logic             last_mem [depth];

  // Pointers carry one extra bit to tell full from empty
  logic [MTU:0] wr_ptr;
  logic [MTU:0] rd_ptr;
  logic [MTU:0] pkt_cnt;
  logic         full;
  logic         wr_en;
  logic         rd_en;

  assign full = (wr_ptr[MTU] != rd_ptr[MTU]) &&
                (wr_ptr[MTU-1:0] == rd_ptr[MTU-1:0]);

  assign o_ready = !full;
  assign wr_en   = i_valid && o_ready;
  assign rd_en   = o_valid && i_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      data_mem[wr_ptr[MTU-1:0]] <= i_data;
      last_mem[wr_ptr[MTU-1:0]] <= i_last;
    end
  end

  // Read is asynchronous from the registered read pointer
  assign o_data = data_mem[rd_ptr[MTU-1:0]];
  assign o_last = last_mem[rd_ptr[MTU-1:0]];

  // ----------------------------------------
  // Pointers and complete packet count
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pkt_cnt <= '0;
    end else begin
      case ({wr_en && i_last, rd_en && o_last})
        2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
        2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
        default: pkt_cnt <= pkt_cnt;
      endcase
    end
  end

  // Only whole packets are visible at the output
  assign o_valid = (pkt_cnt != '0);

endmodule

`default_nettype wire

//--- stream_fifo.sv
/*
  Stream FIFO
  Small register FIFO with valid/ready on both sides and a payload type
  given as a parameter
*/

`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 2
) (
  input  logic clk,
  input  logic reset,
  input  T     i_data,
  input  logic i_valid,
  output logic o_ready,
  output T     o_data,
  output logic o_valid,
  input  logic i_ready
);

  localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int cnt_w = $clog2(DEPTH + 1);

  T               mem [DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             push;
  logic             pop;

  assign push    = i_valid && o_ready;
  assign pop     = o_valid && i_ready;
  assign o_ready = (count != cnt_w'(DEPTH));
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at DEPTH, which need not be a power of two
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- chdr_route_pkg.sv
/*
  CHDR routing definitions
  Word width, endpoint ID field position and packet ID codes shared by
  the ingress buffer, the routing table and the testbench
*/

`default_nettype none

package chdr_route_pkg;

  // ----------------------------------------
  // Word and field layout
  // ----------------------------------------

  // Data word width
  localparam int chdr_w = 64;

  // Destination endpoint ID sits in the low bits of the first word
  localparam int epid_w   = 16;
  localparam int epid_lsb = 0;

  typedef logic [epid_w-1:0] epid_t;

  // ----------------------------------------
  // Packet routing classes
  // ----------------------------------------

  typedef logic [1:0] pkt_id_t;

  // Code 3 is treated the same as ID_DATA
  localparam pkt_id_t ID_DATA       = 2'd0;
  localparam pkt_id_t ID_ROUTE_EPID = 2'd1;
  localparam pkt_id_t ID_RETURN_SRC = 2'd2;

  // Pull the destination endpoint ID out of a first word
  function automatic epid_t get_dst_epid(input logic [chdr_w-1:0] word);
    return word[epid_lsb +: epid_w];
  endfunction

endpackage

`default_nettype wire
